//--- rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    ////////////////////////////////////////
    // Word geometry
    ////////////////////////////////////////

    // Bytes per memory word
    localparam int BYTE_LANES = 4;

    typedef logic [8*BYTE_LANES-1:0] data_t;
    typedef logic [31:0] addr_t;

    // Bit i enables bits 8i+7 to 8i
    typedef logic [BYTE_LANES-1:0] byte_en_t;

    ////////////////////////////////////////
    // Access size codes
    ////////////////////////////////////////

    // Suffix _U means zero extension, otherwise sign extension
    typedef enum logic [2:0] {
        LOAD_WORD   = 3'd0,
        LOAD_HALF   = 3'd1,
        LOAD_HALF_U = 3'd2,
        LOAD_BYTE   = 3'd3,
        LOAD_BYTE_U = 3'd4
    } load_sel_t;

    typedef enum logic [1:0] {
        STORE_WORD = 2'd0,
        STORE_HALF = 2'd1,
        STORE_BYTE = 2'd2
    } store_sel_t;

endpackage

`default_nettype wire

//--- rtl/fetch_port.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_port #(
    parameter int depth_words = 256
) (
    input  wire                          ui_clk_from_ddr,
    input  wire                          reset,
    // Core side
    input  wire                          fetch_req,
    input  mem_pkg::addr_t               fetch_pc,
    output logic                         fetch_ack,
    output mem_pkg::data_t               fetch_instr,
    // Arbiter side
    output logic                         mem_req,
    output logic [$clog2(depth_words)-1:0] mem_index,
    input  wire                          mem_ack,
    input  mem_pkg::data_t               mem_rdata
);

    localparam int index_width = $clog2(depth_words);

    typedef enum logic [1:0] {
        state_idle,
        state_wait,
        state_ack
    } state_t;

    state_t state;

    // Handshake sequencing on both sides
    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            state     <= state_idle;
            mem_req   <= 1'b0;
            fetch_ack <= 1'b0;
        end else begin
            case (state)
                state_idle: begin
                    if (fetch_req) begin
                        mem_req <= 1'b1;
                        state   <= state_wait;
                    end
                end
                state_wait: begin
                    if (mem_ack) begin
                        mem_req   <= 1'b0;
                        fetch_ack <= 1'b1;
                        state     <= state_ack;
                    end
                end
                state_ack: begin
                    // Memory side must be fully closed before a new request
                    if (!fetch_req && !mem_ack) begin
                        fetch_ack <= 1'b0;
                        state     <= state_idle;
                    end
                end
                default: state <= state_idle;
            endcase
        end
    end

    // Word index and returned instruction
    always_ff @(posedge ui_clk_from_ddr) begin
        if (state == state_idle && fetch_req) begin
            mem_index <= fetch_pc[index_width+1:2];
        end
        if (state == state_wait && mem_ack) begin
            fetch_instr <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

//--- rtl/load_store_port.sv
`timescale 1ns/1ps
`default_nettype none

module load_store_port #(
    parameter int depth_words = 256
) (
    input  wire                          ui_clk_from_ddr,
    input  wire                          reset,
    // Core side
    input  wire                          data_req,
    input  wire                          data_write,
    input  mem_pkg::addr_t               data_addr,
    input  mem_pkg::load_sel_t           data_load_sel,
    input  mem_pkg::store_sel_t          data_store_sel,
    input  mem_pkg::data_t               data_wdata,
    output logic                         data_ack,
    output mem_pkg::data_t               data_rdata,
    // Arbiter side
    output logic                         mem_req,
    output logic                         mem_write,
    output logic [$clog2(depth_words)-1:0] mem_index,
    output mem_pkg::data_t               mem_wdata,
    output mem_pkg::byte_en_t            mem_byte_en,
    input  wire                          mem_ack,
    input  mem_pkg::data_t               mem_rdata
);

    localparam int index_width = $clog2(depth_words);

    typedef enum logic [1:0] {
        state_idle,
        state_wait,
        state_ack
    } state_t;

    state_t state;

    mem_pkg::data_t     store_wdata;
    mem_pkg::byte_en_t  store_be;
    mem_pkg::data_t     load_word;
    logic [7:0]         load_byte;
    logic [15:0]        load_half;
    logic [1:0]         load_offset;
    mem_pkg::load_sel_t load_sel;

    ////////////////////////////////////////
    // Store shifter
    ////////////////////////////////////////

    // Narrow data goes to every lane, byte enables pick the lane
    always_comb begin
        case (data_store_sel)
            mem_pkg::STORE_BYTE: begin
                store_wdata = {4{data_wdata[7:0]}};
                store_be    = mem_pkg::byte_en_t'(1) << data_addr[1:0];
            end
            mem_pkg::STORE_HALF: begin
                store_wdata = {2{data_wdata[15:0]}};
                store_be    = data_addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                store_wdata = data_wdata;
                store_be    = '1;
            end
        endcase
    end

    ////////////////////////////////////////
    // Load shifter
    ////////////////////////////////////////

    assign load_byte = mem_rdata[{load_offset, 3'b000} +: 8];
    assign load_half = load_offset[1] ? mem_rdata[31:16] : mem_rdata[15:0];

    always_comb begin
        case (load_sel)
            mem_pkg::LOAD_HALF:   load_word = {{16{load_half[15]}}, load_half};
            mem_pkg::LOAD_HALF_U: load_word = {16'h0000, load_half};
            mem_pkg::LOAD_BYTE:   load_word = {{24{load_byte[7]}}, load_byte};
            mem_pkg::LOAD_BYTE_U: load_word = {24'h000000, load_byte};
            default:              load_word = mem_rdata;
        endcase
    end

    ////////////////////////////////////////
    // Handshake FSM
    ////////////////////////////////////////

    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            state    <= state_idle;
            mem_req  <= 1'b0;
            data_ack <= 1'b0;
        end else begin
            case (state)
                state_idle: begin
                    if (data_req) begin
                        mem_req <= 1'b1;
                        state   <= state_wait;
                    end
                end
                state_wait: begin
                    if (mem_ack) begin
                        mem_req  <= 1'b0;
                        data_ack <= 1'b1;
                        state    <= state_ack;
                    end
                end
                state_ack: begin
                    // Wait for the arbiter side to close as well
                    if (!data_req && !mem_ack) begin
                        data_ack <= 1'b0;
                        state    <= state_idle;
                    end
                end
                default: state <= state_idle;
            endcase
        end
    end

    // Access payload captured at request, load result at memory ack
    always_ff @(posedge ui_clk_from_ddr) begin
        if (state == state_idle && data_req) begin
            mem_write   <= data_write;
            mem_index   <= data_addr[index_width+1:2];
            mem_wdata   <= store_wdata;
            mem_byte_en <= data_write ? store_be : '0;
            load_offset <= data_addr[1:0];
            load_sel    <= data_load_sel;
        end
        if (state == state_wait && mem_ack && !mem_write) begin
            data_rdata <= load_word;
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
    parameter int depth_words = 256
) (
    input  wire                            ui_clk_from_ddr,
    input  wire                            reset,
    // Fetch port
    input  wire                            fetch_mem_req,
    input  wire [$clog2(depth_words)-1:0]  fetch_mem_index,
    output logic                           fetch_mem_ack,
    output mem_pkg::data_t                 fetch_mem_rdata,
    // Load/store port
    input  wire                            data_mem_req,
    input  wire                            data_mem_write,
    input  wire [$clog2(depth_words)-1:0]  data_mem_index,
    input  mem_pkg::data_t                 data_mem_wdata,
    input  mem_pkg::byte_en_t              data_mem_byte_en,
    output logic                           data_mem_ack,
    output mem_pkg::data_t                 data_mem_rdata,
    // Memory
    output logic                           mem_req,
    output logic                           mem_write,
    output logic [$clog2(depth_words)-1:0] mem_index,
    output mem_pkg::data_t                 mem_wdata,
    output mem_pkg::byte_en_t              mem_byte_en,
    input  wire                            mem_ack,
    input  mem_pkg::data_t                 mem_rdata
);

    // One-hot grant, bit 0 fetch and bit 1 data
    logic [1:0] grant;
    logic       last_data;
    logic       pick_data;
    logic       granted_req;

    // Contention goes to the port that lost last time
    assign pick_data   = data_mem_req && (!fetch_mem_req || !last_data);
    assign granted_req = (grant[0] && fetch_mem_req) || (grant[1] && data_mem_req);

    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            grant     <= 2'b00;
            last_data <= 1'b1;
            mem_req   <= 1'b0;
        end else if (grant == 2'b00) begin
            if (fetch_mem_req || data_mem_req) begin
                grant     <= pick_data ? 2'b10 : 2'b01;
                last_data <= pick_data;
                mem_req   <= 1'b1;
            end
        end else if (mem_req) begin
            if (!granted_req) begin
                mem_req <= 1'b0;
            end
        end else if (!mem_ack) begin
            // Memory cycle closed
            grant <= 2'b00;
        end
    end

    // Fetches are always plain reads
    assign mem_write   = grant[1] && data_mem_write;
    assign mem_index   = grant[1] ? data_mem_index : fetch_mem_index;
    assign mem_wdata   = grant[1] ? data_mem_wdata : '0;
    assign mem_byte_en = grant[1] ? data_mem_byte_en : '0;

    assign fetch_mem_ack   = grant[0] && mem_ack;
    assign data_mem_ack    = grant[1] && mem_ack;
    assign fetch_mem_rdata = mem_rdata;
    assign data_mem_rdata  = mem_rdata;

endmodule

`default_nettype wire

//--- rtl/word_memory.sv
`timescale 1ns/1ps
`default_nettype none

module word_memory #(
    parameter int depth_words = 256
) (
    input  wire                           ui_clk_from_ddr,
    input  wire                           reset,
    input  wire                           mem_req,
    input  wire                           mem_write,
    input  wire [$clog2(depth_words)-1:0] mem_index,
    input  mem_pkg::data_t                mem_wdata,
    input  mem_pkg::byte_en_t             mem_byte_en,
    output logic                          mem_ack,
    output mem_pkg::data_t                mem_rdata
);

    mem_pkg::data_t mem_words [depth_words];

    ////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////

    // Ack follows req by one cycle in both directions
    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            mem_ack <= 1'b0;
        end else if (mem_req && !mem_ack) begin
            mem_ack <= 1'b1;
        end else if (!mem_req && mem_ack) begin
            mem_ack <= 1'b0;
        end
    end

    ////////////////////////////////////////
    // Storage
    ////////////////////////////////////////

    // Access happens on the edge that raises ack
    always_ff @(posedge ui_clk_from_ddr) begin
        if (mem_req && !mem_ack) begin
            if (mem_write) begin
                for (int lane = 0; lane < mem_pkg::BYTE_LANES; lane++) begin
                    if (mem_byte_en[lane]) begin
                        mem_words[mem_index][8*lane +: 8] <= mem_wdata[8*lane +: 8];
                    end
                end
            end
            mem_rdata <= mem_words[mem_index];
        end
    end

endmodule

`default_nettype wire

//--- rtl/mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem #(
    parameter int depth_words = 256
) (
    input  wire                 ui_clk_from_ddr,
    input  wire                 reset,
    // Instruction fetch
    input  wire                 fetch_req,
    input  mem_pkg::addr_t      fetch_pc,
    output logic                fetch_ack,
    output mem_pkg::data_t      fetch_instr,
    // Data load/store
    input  wire                 data_req,
    input  wire                 data_write,
    input  mem_pkg::addr_t      data_addr,
    input  mem_pkg::load_sel_t  data_load_sel,
    input  mem_pkg::store_sel_t data_store_sel,
    input  mem_pkg::data_t      data_wdata,
    output logic                data_ack,
    output mem_pkg::data_t      data_rdata
);

    localparam int index_width = $clog2(depth_words);

    ////////////////////////////////////////
    // Port to arbiter
    ////////////////////////////////////////

    logic                   fetch_mem_req;
    logic [index_width-1:0] fetch_mem_index;
    logic                   fetch_mem_ack;
    mem_pkg::data_t         fetch_mem_rdata;

    logic                   data_mem_req;
    logic                   data_mem_write;
    logic [index_width-1:0] data_mem_index;
    mem_pkg::data_t         data_mem_wdata;
    mem_pkg::byte_en_t      data_mem_byte_en;
    logic                   data_mem_ack;
    mem_pkg::data_t         data_mem_rdata;

    // Arbiter to memory
    logic                   mem_req;
    logic                   mem_write;
    logic [index_width-1:0] mem_index;
    mem_pkg::data_t         mem_wdata;
    mem_pkg::byte_en_t      mem_byte_en;
    logic                   mem_ack;
    mem_pkg::data_t         mem_rdata;

    fetch_port #(
        .depth_words ( depth_words )
    ) u_fetch_port (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .reset           ( reset           ),
        .fetch_req       ( fetch_req       ),
        .fetch_pc        ( fetch_pc        ),
        .fetch_ack       ( fetch_ack       ),
        .fetch_instr     ( fetch_instr     ),
        .mem_req         ( fetch_mem_req   ),
        .mem_index       ( fetch_mem_index ),
        .mem_ack         ( fetch_mem_ack   ),
        .mem_rdata       ( fetch_mem_rdata )
    );

    load_store_port #(
        .depth_words ( depth_words )
    ) u_load_store_port (
        .ui_clk_from_ddr ( ui_clk_from_ddr  ),
        .reset           ( reset            ),
        .data_req        ( data_req         ),
        .data_write      ( data_write       ),
        .data_addr       ( data_addr        ),
        .data_load_sel   ( data_load_sel    ),
        .data_store_sel  ( data_store_sel   ),
        .data_wdata      ( data_wdata       ),
        .data_ack        ( data_ack         ),
        .data_rdata      ( data_rdata       ),
        .mem_req         ( data_mem_req     ),
        .mem_write       ( data_mem_write   ),
        .mem_index       ( data_mem_index   ),
        .mem_wdata       ( data_mem_wdata   ),
        .mem_byte_en     ( data_mem_byte_en ),
        .mem_ack         ( data_mem_ack     ),
        .mem_rdata       ( data_mem_rdata   )
    );

    mem_arbiter #(
        .depth_words ( depth_words )
    ) u_mem_arbiter (
        .ui_clk_from_ddr  ( ui_clk_from_ddr  ),
        .reset            ( reset            ),
        .fetch_mem_req    ( fetch_mem_req    ),
        .fetch_mem_index  ( fetch_mem_index  ),
        .fetch_mem_ack    ( fetch_mem_ack    ),
        .fetch_mem_rdata  ( fetch_mem_rdata  ),
        .data_mem_req     ( data_mem_req     ),
        .data_mem_write   ( data_mem_write   ),
        .data_mem_index   ( data_mem_index   ),
        .data_mem_wdata   ( data_mem_wdata   ),
        .data_mem_byte_en ( data_mem_byte_en ),
        .data_mem_ack     ( data_mem_ack     ),
        .data_mem_rdata   ( data_mem_rdata   ),
        .mem_req          ( mem_req          ),
        .mem_write        ( mem_write        ),
        .mem_index        ( mem_index        ),
        .mem_wdata        ( mem_wdata        ),
        .mem_byte_en      ( mem_byte_en      ),
        .mem_ack          ( mem_ack          ),
        .mem_rdata        ( mem_rdata        )
    );

    word_memory #(
        .depth_words ( depth_words )
    ) u_word_memory (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .reset           ( reset           ),
        .mem_req         ( mem_req         ),
        .mem_write       ( mem_write       ),
        .mem_index       ( mem_index       ),
        .mem_wdata       ( mem_wdata       ),
        .mem_byte_en     ( mem_byte_en     ),
        .mem_ack         ( mem_ack         ),
        .mem_rdata       ( mem_rdata       )
    );

endmodule

`default_nettype wire

//--- test/mem_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_tb;

    localparam int depth_words = 64;
    localparam int index_width = $clog2(depth_words);
    localparam int wait_limit  = 50;
    localparam int pair_count  = 200;

    logic                ui_clk_from_ddr;
    logic                reset;
    logic                fetch_req;
    mem_pkg::addr_t      fetch_pc;
    logic                fetch_ack;
    mem_pkg::data_t      fetch_instr;
    logic                data_req;
    logic                data_write;
    mem_pkg::addr_t      data_addr;
    mem_pkg::load_sel_t  data_load_sel;
    mem_pkg::store_sel_t data_store_sel;
    mem_pkg::data_t      data_wdata;
    logic                data_ack;
    mem_pkg::data_t      data_rdata;

    // Reference copy of the memory contents
    mem_pkg::data_t ref_mem [depth_words];

    int value_errors    = 0;
    int timeout_errors  = 0;
    int protocol_errors = 0;

    logic prev_fetch_req = 1'b0;
    logic prev_fetch_ack = 1'b0;
    logic prev_data_req  = 1'b0;
    logic prev_data_ack  = 1'b0;

    mem_subsystem #(
        .depth_words ( depth_words )
    ) uut (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .reset           ( reset           ),
        .fetch_req       ( fetch_req       ),
        .fetch_pc        ( fetch_pc        ),
        .fetch_ack       ( fetch_ack       ),
        .fetch_instr     ( fetch_instr     ),
        .data_req        ( data_req        ),
        .data_write      ( data_write      ),
        .data_addr       ( data_addr       ),
        .data_load_sel   ( data_load_sel   ),
        .data_store_sel  ( data_store_sel  ),
        .data_wdata      ( data_wdata      ),
        .data_ack        ( data_ack        ),
        .data_rdata      ( data_rdata      )
    );

    always #10 ui_clk_from_ddr = ~ui_clk_from_ddr;

    ////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////

    function automatic logic [index_width-1:0] word_index(input mem_pkg::addr_t addr);
        return addr[index_width+1:2];
    endfunction

    // Merge the new bytes into the model word under a lane mask
    function automatic void model_store(input mem_pkg::addr_t addr,
                                        input mem_pkg::store_sel_t sel,
                                        input mem_pkg::data_t wdata);
        mem_pkg::data_t mask;
        mem_pkg::data_t shifted;
        case (sel)
            mem_pkg::STORE_BYTE: begin
                mask    = 32'h0000_00ff << (8 * addr[1:0]);
                shifted = mem_pkg::data_t'(wdata[7:0]) << (8 * addr[1:0]);
            end
            mem_pkg::STORE_HALF: begin
                mask    = 32'h0000_ffff << (16 * addr[1]);
                shifted = mem_pkg::data_t'(wdata[15:0]) << (16 * addr[1]);
            end
            default: begin
                mask    = 32'hffff_ffff;
                shifted = wdata;
            end
        endcase
        ref_mem[word_index(addr)] = (ref_mem[word_index(addr)] & ~mask) | (shifted & mask);
    endfunction

    function automatic mem_pkg::data_t model_load(input mem_pkg::addr_t addr,
                                                  input mem_pkg::load_sel_t sel);
        mem_pkg::data_t word;
        mem_pkg::data_t result;
        logic [7:0]     part_byte;
        logic [15:0]    part_half;
        word      = ref_mem[word_index(addr)];
        part_byte = 8'(word >> (8 * addr[1:0]));
        part_half = 16'(word >> (16 * addr[1]));
        case (sel)
            mem_pkg::LOAD_HALF:   result = mem_pkg::data_t'($signed(part_half));
            mem_pkg::LOAD_HALF_U: result = mem_pkg::data_t'(part_half);
            mem_pkg::LOAD_BYTE:   result = mem_pkg::data_t'($signed(part_byte));
            mem_pkg::LOAD_BYTE_U: result = mem_pkg::data_t'(part_byte);
            default:              result = word;
        endcase
        return result;
    endfunction

    function automatic mem_pkg::load_sel_t random_load_sel();
        return mem_pkg::load_sel_t'(3'($urandom_range(4, 0)));
    endfunction

    function automatic mem_pkg::store_sel_t random_store_sel(input bit narrow_only);
        if (narrow_only) begin
            return $urandom_range(1, 0) ? mem_pkg::STORE_HALF : mem_pkg::STORE_BYTE;
        end
        return mem_pkg::store_sel_t'(2'($urandom_range(2, 0)));
    endfunction

    ////////////////////////////////////////
    // Core-side transactions
    ////////////////////////////////////////

    task automatic next_cycle();
        @(posedge ui_clk_from_ddr);
        #1;
    endtask

    task automatic report_mismatch(input string name, input mem_pkg::data_t expected,
                                   input mem_pkg::data_t actual);
        value_errors++;
        $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
    endtask

    task automatic fetch_word(input mem_pkg::addr_t pc, output mem_pkg::data_t instr,
                              output bit ok);
        int cycles;
        ok        = 1'b0;
        instr     = '0;
        fetch_pc  = pc;
        fetch_req = 1'b1;
        cycles    = 0;
        while (!fetch_ack && cycles < wait_limit) begin
            next_cycle();
            cycles++;
        end
        if (!fetch_ack) begin
            timeout_errors++;
            $display("Timeout at %0t: fetch_ack never rose for PC %h", $time, pc);
            fetch_req = 1'b0;
        end else begin
            instr     = fetch_instr;
            fetch_req = 1'b0;
            cycles    = 0;
            while (fetch_ack && cycles < wait_limit) begin
                next_cycle();
                cycles++;
            end
            if (fetch_ack) begin
                timeout_errors++;
                $display("Timeout at %0t: fetch_ack stayed high after fetch_req fell", $time);
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic data_access(input bit write, input mem_pkg::addr_t addr,
                               input mem_pkg::load_sel_t lsel,
                               input mem_pkg::store_sel_t ssel,
                               input mem_pkg::data_t wdata,
                               output mem_pkg::data_t rdata, output bit ok);
        int cycles;
        ok             = 1'b0;
        rdata          = '0;
        data_write     = write;
        data_addr      = addr;
        data_load_sel  = lsel;
        data_store_sel = ssel;
        data_wdata     = wdata;
        data_req       = 1'b1;
        cycles         = 0;
        while (!data_ack && cycles < wait_limit) begin
            next_cycle();
            cycles++;
        end
        if (!data_ack) begin
            timeout_errors++;
            $display("Timeout at %0t: data_ack never rose for address %h", $time, addr);
            data_req = 1'b0;
        end else begin
            rdata    = data_rdata;
            data_req = 1'b0;
            cycles   = 0;
            while (data_ack && cycles < wait_limit) begin
                next_cycle();
                cycles++;
            end
            if (data_ack) begin
                timeout_errors++;
                $display("Timeout at %0t: data_ack stayed high after data_req fell", $time);
            end else begin
                ok = 1'b1;
            end
        end
    endtask

    ////////////////////////////////////////
    // Handshake monitor
    ////////////////////////////////////////

    // Sampled mid-cycle, away from both edges
    always @(negedge ui_clk_from_ddr) begin
        if (!reset) begin
            if (fetch_ack && !prev_fetch_ack && !prev_fetch_req) begin
                protocol_errors++;
                $display("Handshake error at %0t: fetch_ack rose while fetch_req was low", $time);
            end
            if (!fetch_ack && prev_fetch_ack && prev_fetch_req) begin
                protocol_errors++;
                $display("Handshake error at %0t: fetch_ack fell before fetch_req did", $time);
            end
            if (data_ack && !prev_data_ack && !prev_data_req) begin
                protocol_errors++;
                $display("Handshake error at %0t: data_ack rose while data_req was low", $time);
            end
            if (!data_ack && prev_data_ack && prev_data_req) begin
                protocol_errors++;
                $display("Handshake error at %0t: data_ack fell before data_req did", $time);
            end
        end
        prev_fetch_req = fetch_req;
        prev_fetch_ack = fetch_ack;
        prev_data_req  = data_req;
        prev_data_ack  = data_ack;
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        mem_pkg::addr_t      addr;
        mem_pkg::addr_t      pc;
        mem_pkg::data_t      wdata;
        mem_pkg::data_t      got;
        mem_pkg::data_t      expected;
        mem_pkg::data_t      fetch_got;
        mem_pkg::data_t      fetch_expected;
        mem_pkg::load_sel_t  lsel;
        mem_pkg::store_sel_t ssel;
        bit                  write;
        bit                  ok;
        bit                  fetch_ok;

        void'($urandom(32'h6927));
        ui_clk_from_ddr = 1'b0;
        reset           = 1'b1;
        fetch_req       = 1'b0;
        fetch_pc        = '0;
        data_req        = 1'b0;
        data_write      = 1'b0;
        data_addr       = '0;
        data_load_sel   = mem_pkg::LOAD_WORD;
        data_store_sel  = mem_pkg::STORE_WORD;
        data_wdata      = '0;

        repeat (3) @(posedge ui_clk_from_ddr);
        #1;
        reset = 1'b0;
        if (fetch_ack !== 1'b0 || data_ack !== 1'b0) begin
            value_errors++;
            $display("Fail at %0t: fetch_ack/data_ack expected 0/0, got %b/%b",
                     $time, fetch_ack, data_ack);
        end

        // Fill every word, then read all of them back
        for (int i = 0; i < depth_words; i++) begin
            addr  = mem_pkg::addr_t'(i) << 2;
            wdata = $urandom();
            data_access(1'b1, addr, mem_pkg::LOAD_WORD, mem_pkg::STORE_WORD, wdata, got, ok);
            model_store(addr, mem_pkg::STORE_WORD, wdata);
        end
        for (int i = 0; i < depth_words; i++) begin
            addr     = mem_pkg::addr_t'(i) << 2;
            expected = model_load(addr, mem_pkg::LOAD_WORD);
            data_access(1'b0, addr, mem_pkg::LOAD_WORD, mem_pkg::STORE_WORD, '0, got, ok);
            if (ok && got !== expected) report_mismatch("data_rdata", expected, got);
        end

        // Narrow stores, each followed by a word read of the same word
        for (int n = 0; n < 150; n++) begin
            addr  = $urandom();
            ssel  = random_store_sel(1'b1);
            wdata = $urandom();
            data_access(1'b1, addr, mem_pkg::LOAD_WORD, ssel, wdata, got, ok);
            model_store(addr, ssel, wdata);
            expected = model_load(addr, mem_pkg::LOAD_WORD);
            data_access(1'b0, addr, mem_pkg::LOAD_WORD, mem_pkg::STORE_WORD, '0, got, ok);
            if (ok && got !== expected) report_mismatch("data_rdata", expected, got);
        end

        // Loads of every size and extension
        for (int n = 0; n < 200; n++) begin
            addr     = $urandom();
            lsel     = random_load_sel();
            expected = model_load(addr, lsel);
            data_access(1'b0, addr, lsel, mem_pkg::STORE_WORD, '0, got, ok);
            if (ok && got !== expected) report_mismatch("data_rdata", expected, got);
        end

        // Fetches with arbitrary low PC bits
        for (int n = 0; n < 100; n++) begin
            pc             = $urandom();
            fetch_expected = ref_mem[word_index(pc)];
            fetch_word(pc, fetch_got, fetch_ok);
            if (fetch_ok && fetch_got !== fetch_expected) begin
                report_mismatch("fetch_instr", fetch_expected, fetch_got);
            end
        end

        // Both ports raised in the same cycle
        for (int n = 0; n < pair_count; n++) begin
            pc    = $urandom();
            addr  = $urandom();
            write = 1'($urandom_range(1, 0));
            // A store never targets the word being fetched
            if (write && word_index(addr) == word_index(pc)) addr = addr ^ 32'h4;
            lsel           = random_load_sel();
            ssel           = random_store_sel(1'b0);
            wdata          = $urandom();
            fetch_expected = ref_mem[word_index(pc)];
            expected       = model_load(addr, lsel);
            fork
                fetch_word(pc, fetch_got, fetch_ok);
                data_access(write, addr, lsel, ssel, wdata, got, ok);
            join
            if (write) model_store(addr, ssel, wdata);
            if (fetch_ok && fetch_got !== fetch_expected) begin
                report_mismatch("fetch_instr", fetch_expected, fetch_got);
            end
            if (ok && !write && got !== expected) report_mismatch("data_rdata", expected, got);
        end

        $display("Errors: %0d value, %0d timeout, %0d handshake",
                 value_errors, timeout_errors, protocol_errors);
        if (value_errors == 0 && timeout_errors == 0 && protocol_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
rtl/mem_pkg.sv
rtl/fetch_port.sv
rtl/load_store_port.sv
rtl/mem_arbiter.sv
rtl/word_memory.sv
rtl/mem_subsystem.sv
test/mem_subsystem_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module mem_subsystem_tb -o mem_subsystem_sim

output=$(./obj_dir/mem_subsystem_sim)
echo "$output"

if echo "$output" | grep -qxF '*** PASSED ***'; then
    exit 0
else
    exit 1
fi
